/* hdl/issue_config.svh */
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// datapath widths.
`define INST_WIDTH            32  // one instruction word.
`define ADDR_WIDTH            32  // pc width.
`define INSTRUCTION_ID_WIDTH  8   // program-order tag.

// register file and opcode sizing.
`define OP_CODE_BITS          6   // major opcode.
`define NUM_REGISTERS_LOG2    5   // 32 architectural registers.

// instruction field positions.
`define OPCODE_MSB            31
`define OPCODE_LSB            26
`define REG_RS_MSB            25  // first source.
`define REG_RS_LSB            21
`define REG_RT_MSB            20  // second source or immediate dest.
`define REG_RT_LSB            16
`define REG_RD_MSB            15  // alu destination.
`define REG_RD_LSB            11

`endif

/* hdl/isa_pkg.sv */
`include "issue_config.svh"

package isa_pkg;

  ////////////////////
  // opcode map, top two bits pick the group.
  typedef enum logic [`OP_CODE_BITS-1:0] {
    OP_NOP  = 6'b000000,  // all-zero word is a nop.
    OP_JR   = 6'b000001,  // jump register, sits in the alu group range.
    OP_ADD  = 6'b000010,  // 00xxxx register alu.
    OP_SUB  = 6'b000011,
    OP_AND  = 6'b000100,
    OP_OR   = 6'b000101,
    OP_CMP  = 6'b000110,
    OP_ADDI = 6'b010000,  // 01xxxx immediate alu.
    OP_SUBI = 6'b010001,
    OP_CMPI = 6'b010010,
    OP_LW   = 6'b100000,  // 10xxxx memory.
    OP_SW   = 6'b100001,
    OP_LA   = 6'b100010,
    OP_SA   = 6'b100011,
    OP_JMP  = 6'b110000,  // 11xxxx jumps.
    OP_JE   = 6'b110001,
    OP_JO   = 6'b110010
  } opcode_e;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'b00,
    MEM_READ  = 2'b01,  // load in flight.
    MEM_WRITE = 2'b10
  } mem_op_e;

  ////////////////////
  // operand usage.
  typedef struct packed {
    logic rs;
    logic rt;
    logic rd;
  } reg_mask_t;

  typedef struct packed {
    logic [`NUM_REGISTERS_LOG2-1:0] rs;  // raw fields.
    logic [`NUM_REGISTERS_LOG2-1:0] rt;
    logic [`NUM_REGISTERS_LOG2-1:0] rd;
    reg_mask_t                      src;  // fields actually read.
    reg_mask_t                      dst;  // field actually written.
    logic                           is_load;
  } operand_info_t;

endpackage

/* hdl/pipe_pkg.sv */
`include "issue_config.svh"

package pipe_pkg;

  // one bit per pipeline register a hazard can act on.
  typedef struct packed {
    logic pc;     // hold fetch.
    logic if_id;
    logic id_ex;
  } pipe_mask_t;

  ////////////////////
  // one instruction slot, 73 bits.
  typedef struct packed {
    logic                             valid;
    logic [`ADDR_WIDTH-1:0]           pc;
    logic [`INSTRUCTION_ID_WIDTH-1:0] id;           // program-order tag.
    logic [`INST_WIDTH-1:0]           instruction;  // nop when not valid.
  } issue_slot_t;

  typedef struct packed {
    issue_slot_t slot0;
    issue_slot_t slot1;
    logic        first;  // set: slot1 is the older one.
  } issue_pair_t;

  typedef struct packed {
    isa_pkg::mem_op_e               mem_op;   // read when an lw sits in id/ex.
    logic [`NUM_REGISTERS_LOG2-1:0] load_rt;  // register the load writes.
  } load_info_t;

  // empty slot carrying a nop word.
  localparam issue_slot_t BUBBLE_SLOT = '{
    valid:       1'b0,
    pc:          '0,
    id:          '0,
    instruction: {isa_pkg::OP_NOP, {(`INST_WIDTH-`OP_CODE_BITS){1'b0}}}
  };

endpackage

/* hdl/operand_decoder.sv */
`timescale 1ns/1ns

`include "issue_config.svh"

module operand_decoder (
  input  logic [`INST_WIDTH-1:0] instruction,  // word from one if/id slot.
  output isa_pkg::operand_info_t operands
);

  import isa_pkg::*;

  opcode_e opcode;

  assign opcode = opcode_e'(instruction[`OPCODE_MSB:`OPCODE_LSB]);

  always_comb begin
    operands         = '0;  // nop and jumps use no registers.
    operands.rs      = instruction[`REG_RS_MSB:`REG_RS_LSB];
    operands.rt      = instruction[`REG_RT_MSB:`REG_RT_LSB];
    operands.rd      = instruction[`REG_RD_MSB:`REG_RD_LSB];
    operands.is_load = (opcode == OP_LW);

    casez (opcode)
      6'b00????: begin  // register alu group, also nop and jr.
        if (opcode == OP_JR) begin
          operands.src.rs = 1'b1;  // target address in rs.
        end else if (opcode != OP_NOP) begin
          operands.src.rs = 1'b1;
          operands.src.rt = 1'b1;
          operands.dst.rd = 1'b1;
        end
      end
      6'b01????: begin  // immediate alu.
        operands.src.rs = 1'b1;
        operands.dst.rt = 1'b1;
      end
      6'b10????: begin  // memory ops.
        case (opcode)
          OP_LW: begin
            operands.src.rs = 1'b1;  // base.
            operands.dst.rt = 1'b1;
          end
          OP_SW: begin
            operands.src.rs = 1'b1;
            operands.src.rt = 1'b1;  // store data.
          end
          OP_LA:   operands.dst.rt = 1'b1;  // absolute load.
          OP_SA:   operands.src.rt = 1'b1;  // absolute store.
          default: operands.src   = '0;     // unused memory codes.
        endcase
      end
      6'b11????: begin  // jumps, pc-relative only.
        operands.src = '0;
        operands.dst = '0;
      end
    endcase
  end

endmodule

/* hdl/hazard_detection_unit.sv */
`timescale 1ns/1ns

`include "issue_config.svh"

module hazard_detection_unit (
  input  isa_pkg::operand_info_t operands0,  // decoded id slot 0.
  input  isa_pkg::operand_info_t operands1,  // decoded id slot 1.
  input  logic                   first,      // slot1 older.
  input  pipe_pkg::load_info_t   load_info,  // load sitting in id/ex.
  output pipe_pkg::pipe_mask_t   stall0,
  output pipe_pkg::pipe_mask_t   stall1,
  output pipe_pkg::pipe_mask_t   flush0,
  output pipe_pkg::pipe_mask_t   flush1,
  output logic                   fetch_stall
);

  import isa_pkg::*;
  import pipe_pkg::*;

  // mask patterns.
  localparam pipe_mask_t HOLD_PC_IF_ID = '{pc: 1'b1, if_id: 1'b1, id_ex: 1'b0};
  localparam pipe_mask_t HOLD_PC       = '{pc: 1'b1, if_id: 1'b0, id_ex: 1'b0};
  localparam pipe_mask_t KILL_IF_ID    = '{pc: 1'b0, if_id: 1'b1, id_ex: 1'b0};
  localparam pipe_mask_t KILL_ID_EX    = '{pc: 1'b0, if_id: 1'b0, id_ex: 1'b1};

  operand_info_t older;    // slot flagged by first.
  operand_info_t younger;
  logic          load_hit0;
  logic          load_hit1;
  logic          load_stall;
  logic          split_stall;

  // field matches whatever the producer really writes.
  function automatic logic dst_match(input logic [`NUM_REGISTERS_LOG2-1:0] field,
                                     input operand_info_t producer);
    dst_match = (producer.dst.rs && (field == producer.rs)) ||
                (producer.dst.rt && (field == producer.rt)) ||
                (producer.dst.rd && (field == producer.rd));
  endfunction

  ////////////////////
  // load-use, raw fields regardless of opcode.
  assign load_hit0 = (operands0.rs == load_info.load_rt) || (operands0.rt == load_info.load_rt);
  assign load_hit1 = (operands1.rs == load_info.load_rt) || (operands1.rt == load_info.load_rt);
  assign load_stall = (load_info.mem_op == MEM_READ) && (load_hit0 || load_hit1);

  ////////////////////
  // intra-pair raw dependency.
  assign older   = first ? operands1 : operands0;
  assign younger = first ? operands0 : operands1;

  assign split_stall = !load_stall &&              // only without load-use.
                       ((younger.src.rs && dst_match(younger.rs, older)) ||
                        (younger.src.rt && dst_match(younger.rt, older)) ||
                        (younger.src.rd && dst_match(younger.rd, older)));

  ////////////////////
  always_comb begin
    stall0 = '0;
    stall1 = '0;
    flush0 = '0;
    flush1 = '0;
    if (load_stall) begin  // whole pair waits one cycle.
      stall0 = HOLD_PC_IF_ID;
      stall1 = HOLD_PC_IF_ID;
      flush0 = KILL_ID_EX;  // bubble into id/ex.
      flush1 = KILL_ID_EX;
    end else if (split_stall) begin
      if (first) begin  // slot1 older, issues alone.
        stall0 = HOLD_PC_IF_ID;
        flush0 = KILL_ID_EX;
        stall1 = HOLD_PC;
        flush1 = KILL_IF_ID;  // leaves if/id after issue.
      end else begin  // slot0 older.
        stall1 = HOLD_PC_IF_ID;
        flush1 = KILL_ID_EX;
        stall0 = HOLD_PC;
        flush0 = KILL_IF_ID;
      end
    end
  end

  assign fetch_stall = stall0.pc | stall1.pc;  // fetch holds its pair.

endmodule

/* hdl/fetch_pair_register.sv */
`timescale 1ns/1ns

module fetch_pair_register (
  input  logic                  clk,
  input  logic                  rst,
  input  pipe_pkg::issue_pair_t fetch_pair,  // pair offered by fetch.
  input  pipe_pkg::pipe_mask_t  stall0,
  input  pipe_pkg::pipe_mask_t  stall1,
  input  pipe_pkg::pipe_mask_t  flush0,
  input  pipe_pkg::pipe_mask_t  flush1,
  output pipe_pkg::issue_pair_t id_pair      // if/id contents.
);

  import pipe_pkg::*;

  logic hold0;  // slot 0 keeps its contents.
  logic hold1;

  // flush beats stall, stall beats load.
  function automatic issue_slot_t next_slot(input issue_slot_t held,
                                            input issue_slot_t incoming,
                                            input logic        hold,
                                            input pipe_mask_t  flush);
    if (flush.if_id) begin
      next_slot = BUBBLE_SLOT;
    end else if (hold) begin
      next_slot = held;
    end else begin
      next_slot = incoming;
    end
  endfunction

  assign hold0 = stall0.if_id & ~flush0.if_id;
  assign hold1 = stall1.if_id & ~flush1.if_id;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_pair.slot0 <= BUBBLE_SLOT;
      id_pair.slot1 <= BUBBLE_SLOT;
      id_pair.first <= 1'b0;
    end else begin
      id_pair.slot0 <= next_slot(id_pair.slot0, fetch_pair.slot0, hold0, flush0);
      id_pair.slot1 <= next_slot(id_pair.slot1, fetch_pair.slot1, hold1, flush1);
      if (!hold0 && !hold1) begin
        id_pair.first <= fetch_pair.first;  // order kept while a slot waits.
      end
    end
  end

endmodule

/* hdl/execute_pair_register.sv */
`timescale 1ns/1ns

`include "issue_config.svh"

module execute_pair_register (
  input  logic                  clk,
  input  logic                  rst,
  input  pipe_pkg::issue_pair_t id_pair,    // decoded pair from if/id.
  input  pipe_pkg::pipe_mask_t  flush0,
  input  pipe_pkg::pipe_mask_t  flush1,
  output pipe_pkg::issue_pair_t ex_pair,    // issued pair.
  output pipe_pkg::load_info_t  load_info   // in-flight load.
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic                           lw0;     // slot 0 holds a valid lw.
  logic                           lw1;
  logic [`NUM_REGISTERS_LOG2-1:0] lw_rt0;  // rt captured with the slot.
  logic [`NUM_REGISTERS_LOG2-1:0] lw_rt1;
  logic                           take0;   // report slot 0 load.

  function automatic logic is_lw(input issue_slot_t slot);
    is_lw = slot.valid &&
            (opcode_e'(slot.instruction[`OPCODE_MSB:`OPCODE_LSB]) == OP_LW);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_pair.slot0 <= BUBBLE_SLOT;
      ex_pair.slot1 <= BUBBLE_SLOT;
      ex_pair.first <= 1'b0;
      lw0           <= 1'b0;
      lw1           <= 1'b0;
    end else begin
      ex_pair.slot0 <= flush0.id_ex ? BUBBLE_SLOT : id_pair.slot0;
      ex_pair.slot1 <= flush1.id_ex ? BUBBLE_SLOT : id_pair.slot1;
      ex_pair.first <= id_pair.first;
      lw0           <= !flush0.id_ex && is_lw(id_pair.slot0);
      lw1           <= !flush1.id_ex && is_lw(id_pair.slot1);
    end
  end

  always_ff @(posedge clk) begin
    lw_rt0 <= id_pair.slot0.instruction[`REG_RT_MSB:`REG_RT_LSB];
    lw_rt1 <= id_pair.slot1.instruction[`REG_RT_MSB:`REG_RT_LSB];
  end

  // one load per pair is tracked, the younger wins.
  assign take0 = lw0 && (ex_pair.first || !lw1);

  always_comb begin
    load_info.mem_op  = (lw0 || lw1) ? MEM_READ : MEM_NONE;
    load_info.load_rt = take0 ? lw_rt0 : lw_rt1;
  end

endmodule

/* hdl/dual_issue_stage.sv */
`timescale 1ns/1ns

module dual_issue_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  pipe_pkg::issue_pair_t fetch_pair,   // held by fetch while stalled.
  output logic                  fetch_stall,  // level, pair not taken.
  output pipe_pkg::issue_pair_t issue_pair    // id/ex contents.
);

  import isa_pkg::*;
  import pipe_pkg::*;

  issue_pair_t   id_pair;
  operand_info_t operands0;
  operand_info_t operands1;
  pipe_mask_t    stall0;
  pipe_mask_t    stall1;
  pipe_mask_t    flush0;
  pipe_mask_t    flush1;
  load_info_t    load_info;

  ////////////////////
  fetch_pair_register u_if_id (
    .clk(clk), .rst(rst), .fetch_pair(fetch_pair),
    .stall0(stall0), .stall1(stall1), .flush0(flush0), .flush1(flush1),
    .id_pair(id_pair)
  );

  operand_decoder u_decode0 (.instruction(id_pair.slot0.instruction), .operands(operands0));
  operand_decoder u_decode1 (.instruction(id_pair.slot1.instruction), .operands(operands1));

  hazard_detection_unit u_hazard (
    .operands0(operands0), .operands1(operands1), .first(id_pair.first),
    .load_info(load_info),
    .stall0(stall0), .stall1(stall1), .flush0(flush0), .flush1(flush1),
    .fetch_stall(fetch_stall)
  );

  execute_pair_register u_id_ex (
    .clk(clk), .rst(rst), .id_pair(id_pair), .flush0(flush0), .flush1(flush1),
    .ex_pair(issue_pair), .load_info(load_info)
  );

endmodule

/* verif/dual_issue_properties.sv */
`timescale 1ns/1ns

`include "issue_config.svh"

module dual_issue_properties (
  input logic                   clk,
  input logic                   rst,
  input logic                   fetch_stall,
  input pipe_pkg::issue_pair_t  issue_pair,  // id/ex contents.
  input logic                   id_first,    // order bit held in if/id.
  input isa_pkg::operand_info_t operands0,
  input isa_pkg::operand_info_t operands1,
  input pipe_pkg::pipe_mask_t   stall0,
  input pipe_pkg::pipe_mask_t   stall1,
  input pipe_pkg::pipe_mask_t   flush0,
  input pipe_pkg::pipe_mask_t   flush1
);

  import isa_pkg::*;
  import pipe_pkg::*;

  int            fail_count = 0;  // assertion failures so far.
  logic          ex_lw;
  logic          split_cond;
  operand_info_t older;
  operand_info_t younger;

  function automatic logic written(input logic [`NUM_REGISTERS_LOG2-1:0] field,
                                   input operand_info_t p);
    written = (p.dst.rs && field == p.rs) || (p.dst.rt && field == p.rt) ||
              (p.dst.rd && field == p.rd);
  endfunction

  assign ex_lw = (issue_pair.slot0.valid &&
                  issue_pair.slot0.instruction[`OPCODE_MSB:`OPCODE_LSB] == OP_LW) ||
                 (issue_pair.slot1.valid &&
                  issue_pair.slot1.instruction[`OPCODE_MSB:`OPCODE_LSB] == OP_LW);
  assign older      = id_first ? operands1 : operands0;
  assign younger    = id_first ? operands0 : operands1;
  assign split_cond = (younger.src.rs && written(younger.rs, older)) ||
                      (younger.src.rt && written(younger.rt, older)) ||
                      (younger.src.rd && written(younger.rd, older));

  ////////////////////
  masks_idle: assert property (@(posedge clk) disable iff (rst)
    (!ex_lw && !split_cond) |-> (stall0 == '0 && stall1 == '0 && flush0 == '0 && flush1 == '0))
    else begin
      $error("hazard masks set with no load in ID/EX and no split");
      fail_count++;
    end

  reset_release: assert property (@(posedge clk) rst |=> !fetch_stall)
    else begin
      $error("fetch_stall high right after reset");
      fail_count++;
    end

  if_id_excl0: assert property (@(posedge clk) disable iff (rst) !(stall0.if_id && flush0.if_id))
    else begin
      $error("slot 0 stalls and flushes IF/ID together");
      fail_count++;
    end

  if_id_excl1: assert property (@(posedge clk) disable iff (rst) !(stall1.if_id && flush1.if_id))
    else begin
      $error("slot 1 stalls and flushes IF/ID together");
      fail_count++;
    end

endmodule

bind dual_issue_stage dual_issue_properties u_props (
  .clk(clk), .rst(rst), .fetch_stall(fetch_stall), .issue_pair(issue_pair),
  .id_first(id_pair.first), .operands0(operands0), .operands1(operands1),
  .stall0(stall0), .stall1(stall1), .flush0(flush0), .flush1(flush1)
);

/* verif/dual_issue_checker.sv */
`timescale 1ns/1ns

`include "issue_config.svh"

module dual_issue_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  pipe_pkg::issue_pair_t fetch_pair,
  input  logic                  fetch_stall,
  input  pipe_pkg::issue_pair_t issue_pair,
  input  logic                  indep,        // independent phase running.
  output int                    error_count,
  output int                    queue_size    // ids taken but not issued.
);

  import isa_pkg::*;
  import pipe_pkg::*;

  typedef struct packed {
    logic       valid;
    logic       indep;
    logic [7:0] id0;
    logic [7:0] id1;
  } take_rec_t;

  issue_slot_t order_q[$];  // program order, older first.
  take_rec_t   rec1;        // pair taken one cycle back.
  take_rec_t   rec2;
  logic        rst_seen = 1'b0;
  logic        lw_live  = 1'b0;
  logic [4:0]  lw_rt;

  initial error_count = 0;

  ////////////////////
  // reference decode, masks are {rs, rt, rd}.
  function automatic logic [2:0] src_of(input logic [31:0] w);
    logic [5:0] op;
    op = w[`OPCODE_MSB:`OPCODE_LSB];
    if (op == 6'b000000) src_of = 3'b000;       // nop.
    else if (op == 6'b000001) src_of = 3'b100;  // jr.
    else if (op[5:4] == 2'b00) src_of = 3'b110;
    else if (op[5:4] == 2'b01) src_of = 3'b100;
    else if (op == 6'b100000) src_of = 3'b100;  // lw base.
    else if (op == 6'b100001) src_of = 3'b110;
    else if (op == 6'b100011) src_of = 3'b010;  // sa.
    else src_of = 3'b000;
  endfunction

  function automatic logic [2:0] dst_of(input logic [31:0] w);
    logic [5:0] op;
    op = w[`OPCODE_MSB:`OPCODE_LSB];
    if (op[5:4] == 2'b00 && op[5:1] != 5'b00000) dst_of = 3'b001;
    else if (op[5:4] == 2'b01) dst_of = 3'b010;
    else if (op == 6'b100000 || op == 6'b100010) dst_of = 3'b010;  // lw, la.
    else dst_of = 3'b000;
  endfunction

  function automatic logic [4:0] field(input logic [31:0] w, input int k);
    if (k == 2) field = w[25:21];
    else if (k == 1) field = w[20:16];
    else field = w[15:11];
  endfunction

  // younger reads a register the older writes.
  function automatic logic depends(input logic [31:0] young, input logic [31:0] old);
    logic [2:0] s;
    logic [2:0] d;
    s = src_of(young);
    d = dst_of(old);
    depends = 1'b0;
    for (int i = 0; i < 3; i++)
      for (int j = 0; j < 3; j++)
        if (s[i] && d[j] && field(young, i) == field(old, j)) depends = 1'b1;
  endfunction

  function automatic logic is_lw(input issue_slot_t s);
    is_lw = s.valid && s.instruction[31:26] == 6'b100000;
  endfunction

  task automatic pop_check(input issue_slot_t s);
    issue_slot_t exp;
    if (s.valid) begin
      if (order_q.size() == 0) begin
        $display("id %h issued with nothing left to issue", s.id);
        error_count++;
      end else begin
        exp = order_q.pop_front();
        if (s.id != exp.id) begin
          $display("error issue_pair id got %h expected %h", s.id, exp.id);
          error_count++;
        end else if (s.pc != exp.pc) begin
          $display("error issue_pair pc got %h expected %h", s.pc, exp.pc);
          error_count++;
        end else if (s.instruction != exp.instruction) begin
          $display("error issue_pair instruction got %h expected %h",
                   s.instruction, exp.instruction);
          error_count++;
        end
      end
    end
  endtask

  ////////////////////
  always @(negedge clk) begin : watch
    issue_slot_t older_s;
    issue_slot_t younger_s;
    take_rec_t   now_rec;
    if (rst) begin
      rst_seen = 1'b1;
      order_q.delete();
      rec1    = '0;
      rec2    = '0;
      lw_live = 1'b0;
    end else begin
      if (rst_seen) begin  // first cycle out of reset.
        rst_seen = 1'b0;
        if (issue_pair.slot0.valid || issue_pair.slot1.valid) begin
          $display("issue_pair holds a valid slot right after reset");
          error_count++;
        end
        if (fetch_stall) begin
          $display("error fetch_stall got %h expected %h", fetch_stall, 1'b0);
          error_count++;
        end
      end
      older_s   = issue_pair.first ? issue_pair.slot1 : issue_pair.slot0;
      younger_s = issue_pair.first ? issue_pair.slot0 : issue_pair.slot1;
      pop_check(older_s);
      pop_check(younger_s);
      if (older_s.valid && younger_s.valid &&
          depends(younger_s.instruction, older_s.instruction)) begin
        $display("id %h issued together with id %h whose result it reads",
                 younger_s.id, older_s.id);
        error_count++;
      end
      if (lw_live) begin  // slots right behind a load.
        if (older_s.valid && (field(older_s.instruction, 2) == lw_rt ||
            field(older_s.instruction, 1) == lw_rt)) begin
          $display("id %h issued right after a load of r%0d", older_s.id, lw_rt);
          error_count++;
        end
        if (younger_s.valid && (field(younger_s.instruction, 2) == lw_rt ||
            field(younger_s.instruction, 1) == lw_rt)) begin
          $display("id %h issued right after a load of r%0d", younger_s.id, lw_rt);
          error_count++;
        end
      end
      lw_live = is_lw(younger_s) || is_lw(older_s);  // younger load tracked.
      lw_rt   = is_lw(younger_s) ? field(younger_s.instruction, 1)
                                 : field(older_s.instruction, 1);
      if (rec1.valid && rec1.indep && fetch_stall) begin
        $display("error fetch_stall got %h expected %h", fetch_stall, 1'b0);
        error_count++;
      end
      if (rec2.valid && rec2.indep) begin  // fixed two cycle latency.
        if (!issue_pair.slot0.valid || !issue_pair.slot1.valid) begin
          $display("independent pair %h/%h not issued two cycles after it was taken",
                   rec2.id0, rec2.id1);
          error_count++;
        end else if (issue_pair.slot0.id != rec2.id0 || issue_pair.slot1.id != rec2.id1) begin
          $display("error issue_pair.slot0.id got %h expected %h, slot1.id got %h expected %h",
                   issue_pair.slot0.id, rec2.id0, issue_pair.slot1.id, rec2.id1);
          error_count++;
        end
      end
      now_rec = '0;
      if (!fetch_stall) begin  // taken at the next edge.
        older_s   = fetch_pair.first ? fetch_pair.slot1 : fetch_pair.slot0;
        younger_s = fetch_pair.first ? fetch_pair.slot0 : fetch_pair.slot1;
        if (older_s.valid) order_q.push_back(older_s);
        if (younger_s.valid) order_q.push_back(younger_s);
        now_rec.valid = fetch_pair.slot0.valid || fetch_pair.slot1.valid;
        now_rec.indep = indep;
        now_rec.id0   = fetch_pair.slot0.id;
        now_rec.id1   = fetch_pair.slot1.id;
      end
      rec2 = rec1;
      rec1 = now_rec;
    end
    queue_size = order_q.size();
  end

endmodule

/* verif/tb_dual_issue.sv */
`timescale 1ns/1ns

`include "issue_config.svh"

module tb_dual_issue;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int PAIRS_PER_PHASE = 40;
  localparam int NUM_PHASES      = 3;
  localparam int TIMEOUT_CYCLES  = 3 * 2 * PAIRS_PER_PHASE * NUM_PHASES + 100;
  localparam logic [5:0] RANDOM_OPS [16] = '{
    OP_NOP, OP_JR, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_CMP, OP_ADDI,
    OP_SUBI, OP_CMPI, OP_LW, OP_SW, OP_LA, OP_SA, OP_JMP, OP_JE
  };

  logic        clk;
  logic        rst;
  issue_pair_t fetch_pair;
  logic        fetch_stall;
  issue_pair_t issue_pair;
  logic        indep;
  int          error_count;
  int          queue_size;
  logic        ready;        // pair at fetch_pair taken at next edge.
  int          cycle_count = 0;
  logic [31:0] lfsr_state  = 32'h99817aa8;
  logic [7:0]  next_id     = 8'd0;

  dual_issue_stage UUT (
    .clk(clk), .rst(rst), .fetch_pair(fetch_pair),
    .fetch_stall(fetch_stall), .issue_pair(issue_pair)
  );

  dual_issue_checker u_checker (
    .clk(clk), .rst(rst), .fetch_pair(fetch_pair), .fetch_stall(fetch_stall),
    .issue_pair(issue_pair), .indep(indep), .error_count(error_count),
    .queue_size(queue_size)
  );

  ////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);  // galois taps 32 30 26 25.
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic make_word(input int phase, output logic [31:0] w);
    logic [31:0] v;
    logic [5:0]  op;
    logic [1:0]  rs;
    logic [1:0]  rt;
    logic [1:0]  rd;
    take_bits(4, v);
    if (phase == 0) op = OP_ADD + {4'b0000, v[1:0]};  // alu only.
    else if (phase == 1) op = (v[1:0] == 2'd2) ? OP_ADD : (v[1:0] == 2'd3) ? OP_SW : OP_LW;
    else op = RANDOM_OPS[v[3:0]];
    take_bits(6, v);
    rs = v[1:0];
    rt = v[3:2];
    rd = v[5:4];
    if (phase == 0) begin  // reads r0-r1, writes r2-r3.
      rs = {1'b0, rs[0]};
      rt = {1'b0, rt[0]};
      rd = {1'b1, rd[0]};
    end
    w = {op, 3'b000, rs, 3'b000, rt, 3'b000, rd, 11'd0};
  endtask

  task automatic make_pair(input int phase, output issue_pair_t p);
    logic [31:0] v;
    logic [31:0] w0;
    logic [31:0] w1;
    take_bits(1, v);
    make_word(phase, w0);
    make_word(phase, w1);
    p.first = v[0];
    p.slot0 = '{valid: 1'b1, pc: '0, id: '0, instruction: w0};
    p.slot1 = '{valid: 1'b1, pc: '0, id: '0, instruction: w1};
    p.slot0.id = p.first ? next_id + 8'd1 : next_id;  // older slot gets the lower id.
    p.slot1.id = p.first ? next_id : next_id + 8'd1;
    p.slot0.pc = {22'd0, p.slot0.id, 2'b00};
    p.slot1.pc = {22'd0, p.slot1.id, 2'b00};
    next_id = next_id + 8'd2;
  endtask

  // drive a pair and wait for the edge that takes it.
  task automatic send_pair(input issue_pair_t p);
    fetch_pair <= p;
    do @(posedge clk); while (!ready);
  endtask

  ////////////////////
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk) ready = !rst && !fetch_stall;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, issued stream never drained", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin : stimulus
    issue_pair_t p;
    int          total;
    rst        = 1'b1;
    indep      = 1'b0;
    ready      = 1'b0;
    fetch_pair = '{slot0: BUBBLE_SLOT, slot1: BUBBLE_SLOT, first: 1'b0};
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int phase = 0; phase < NUM_PHASES; phase++) begin  // independent, loads, random.
      indep <= (phase == 0);
      for (int k = 0; k < PAIRS_PER_PHASE; k++) begin
        make_pair(phase, p);
        send_pair(p);
      end
    end
    fetch_pair <= '{slot0: BUBBLE_SLOT, slot1: BUBBLE_SLOT, first: 1'b0};
    indep      <= 1'b0;
    while (queue_size != 0) @(posedge clk);
    repeat (3) @(posedge clk);  // catch stray issues.
    total = error_count + UUT.u_props.fail_count;
    $display("errors: checker %0d, assertions %0d", error_count, UUT.u_props.fail_count);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/operand_decoder.sv
hdl/hazard_detection_unit.sv
hdl/fetch_pair_register.sv
hdl/execute_pair_register.sv
hdl/dual_issue_stage.sv
verif/dual_issue_properties.sv
verif/dual_issue_checker.sv
verif/tb_dual_issue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the issue stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_dual_issue -Mdir obj_dir

sim_status=0
./obj_dir/Vtb_dual_issue +verilator+error+limit+1000 > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
exit 0
